/* hw/rvPkg.sv */
package rvPkg;

    localparam int xlen = 32;
    localparam int regCount = 32;               // x0 reads as zero
    localparam int regAddrW = $clog2(regCount);

    // major opcodes, instr[6:0]
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8                         // lui passes the u-immediate through
    } aluFnT;

    // bundle leaving decode, registered again in execute
    typedef struct packed {
        logic                valid;
        logic                we;
        logic                bneq;               // bne rather than beq
        logic                btype;              // conditional branch
        logic                j;                  // jal
        logic                jr;                 // jalr
        logic [regAddrW-1:0] rd;
        aluFnT               aluFn;
        logic [xlen-1:0]     opA;
        logic [xlen-1:0]     opB;                // rs2 or immediate
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     bImm;
        logic [xlen-1:0]     jImm;
    } issueT;

    typedef struct packed {
        logic                valid;
        logic                we;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     result;
    } exeResT;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirectT;

    typedef struct packed {
        logic                en;
        logic [regAddrW-1:0] addr;
        logic [xlen-1:0]     data;
    } regWriteT;

endpackage

/* hw/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import rvPkg::*;
(
    input  aluFnT           aluFn,
    input  logic [xlen-1:0] operandA,
    input  logic [xlen-1:0] operandB,
    input  logic            bneq,
    input  logic            btype,
    output logic [xlen-1:0] result,
    output logic            btaken
);

    logic [4:0] shamt;
    logic       lessThan;
    logic       equal;

    assign shamt    = operandB[4:0];            // only the low 5 bits shift
    assign lessThan = $signed(operandA) < $signed(operandB);
    assign equal    = (operandA == operandB);

    always_comb
    begin
        case (aluFn)
            aluAdd:
                result = operandA + operandB;
            aluSub:
                result = operandA - operandB;
            aluAnd:
                result = operandA & operandB;
            aluOr:
                result = operandA | operandB;
            aluXor:
                result = operandA ^ operandB;
            aluSlt:
                result = {{(xlen-1){1'b0}}, lessThan};
            aluSll:
                result = operandA << shamt;
            aluSrl:
                result = operandA >> shamt;     // logical shift
            aluPassB:
                result = operandB;
            default:
                result = '0;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign btaken = btype & (equal ^ bneq);

endmodule

/* hw/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit import rvPkg::*;
(
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] operandA,
    input  logic [xlen-1:0] bImm,
    input  logic [xlen-1:0] jImm,
    input  logic [xlen-1:0] iImm,
    input  logic            btaken,
    input  logic            j,
    input  logic            jr,
    input  logic            valid,
    output redirectT        redirect
);

    logic [xlen-1:0] jrTarget;

    // jalr clears bit 0 of the sum
    assign jrTarget = (operandA + iImm) & ~{{(xlen-1){1'b0}}, 1'b1};

    always_comb
    begin
        if (jr)
        begin
            redirect.target = jrTarget;
        end
        else if (j)
        begin
            redirect.target = pc + jImm;
        end
        else
        begin
            redirect.target = pc + bImm;        // conditional branch
        end
        redirect.taken = valid & (btaken | j | jr);
    end

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import rvPkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            instrValid,
    input  logic [31:0]     instr,
    input  logic [xlen-1:0] pc,
    input  regWriteT        regWrite,
    output issueT           issue
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [regAddrW-1:0] rd, rs1, rs2;
    logic [xlen-1:0]     iImm, uImm;
    logic [xlen-1:0]     rs1Val, rs2Val;
    logic [xlen-1:0]     rf [regCount];
    issueT               issueD;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign iImm = {{20{instr[31]}}, instr[31:20]};
    assign uImm = {instr[31:12], 12'b0};

    // register file, a write in flight is seen by a read in the same cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                rf[i] <= '0;
            end
        end
        else if (regWrite.en && regWrite.addr != '0)
        begin
            rf[regWrite.addr] <= regWrite.data;
        end
    end

    assign rs1Val = (rs1 == '0) ? '0 :
                    (regWrite.en && regWrite.addr == rs1) ? regWrite.data : rf[rs1];
    assign rs2Val = (rs2 == '0) ? '0 :
                    (regWrite.en && regWrite.addr == rs2) ? regWrite.data : rf[rs2];

    always_comb
    begin
        issueD       = '0;
        issueD.valid = instrValid;
        issueD.rd    = rd;
        issueD.opA   = rs1Val;
        issueD.opB   = rs2Val;
        issueD.pc    = pc;
        issueD.bImm  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        issueD.jImm  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        issueD.aluFn = aluAdd;
        case (opcode)
            opOp, opOpImm:
            begin
                case (funct3)
                    3'b001: issueD.aluFn = aluSll;
                    3'b010: issueD.aluFn = aluSlt;
                    3'b100: issueD.aluFn = aluXor;
                    3'b101: issueD.aluFn = aluSrl;
                    3'b110: issueD.aluFn = aluOr;
                    3'b111: issueD.aluFn = aluAnd;
                    default: issueD.aluFn = (opcode == opOp && funct7[5]) ? aluSub : aluAdd;
                endcase
                if (opcode == opOpImm)
                begin
                    issueD.opB = iImm;
                end
                issueD.we = (rd != '0);
            end
            opLui:
            begin
                issueD.aluFn = aluPassB;
                issueD.opB   = uImm;
                issueD.we    = (rd != '0);
            end
            opBranch:
            begin
                issueD.aluFn = aluSub;          // result unused, compare is in the alu
                issueD.btype = 1'b1;
                issueD.bneq  = funct3[0];
            end
            opJal:  issueD.j = 1'b1;
            opJalr:
            begin
                issueD.jr  = 1'b1;
                issueD.opB = iImm;              // branch unit takes this as iImm
            end
            default: ;                          // unknown opcode, valid but no effect
        endcase
    end

    // stage 4 issue register
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            issue <= '0;
        end
        else
        begin
            issue <= issueD;
        end
    end

endmodule

/* hw/exeStage.sv */
`timescale 1ns/1ps

module exeStage import rvPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  issueT    issue,
    output exeResT   exeRes,
    output redirectT redirect
);

    issueT           issueQ;                    // stage 5 copy of the bundle
    logic [xlen-1:0] aluResult;
    logic            btaken;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            issueQ <= '0;
        end
        else
        begin
            issueQ <= issue;
        end
    end

    aluUnit u_aluUnit (
        .aluFn    (issueQ.aluFn),
        .operandA (issueQ.opA),
        .operandB (issueQ.opB),
        .bneq     (issueQ.bneq),
        .btype    (issueQ.btype),
        .result   (aluResult),
        .btaken   (btaken)
    );

    // jalr immediate travels in opB
    branchUnit u_branchUnit (
        .pc       (issueQ.pc),
        .operandA (issueQ.opA),
        .bImm     (issueQ.bImm),
        .jImm     (issueQ.jImm),
        .iImm     (issueQ.opB),
        .btaken   (btaken),
        .j        (issueQ.j),
        .jr       (issueQ.jr),
        .valid    (issueQ.valid),
        .redirect (redirect)
    );

    assign exeRes.valid  = issueQ.valid;
    assign exeRes.we     = issueQ.we;
    assign exeRes.rd     = issueQ.rd;
    assign exeRes.result = aluResult;

endmodule

/* hw/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage import rvPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  exeResT   exeRes,
    output regWriteT regWrite
);

    logic                wbEn;
    logic [regAddrW-1:0] wbAddr;
    logic [xlen-1:0]     wbData;

    // own pipeline slot, the register file sees the write one edge later
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wbEn <= 1'b0;
        end
        else
        begin
            wbEn <= exeRes.valid & exeRes.we;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wbAddr <= '0;
            wbData <= '0;
        end
        else
        begin
            wbAddr <= exeRes.rd;
            wbData <= exeRes.result;
        end
    end

    assign regWrite.en   = wbEn;
    assign regWrite.addr = wbAddr;
    assign regWrite.data = wbData;

endmodule

/* hw/exeTop.sv */
`timescale 1ns/1ps

module exeTop import rvPkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            instrValid,
    input  logic [31:0]     instr,
    input  logic [xlen-1:0] pc,
    output redirectT        redirect,
    output regWriteT        wb
);

    issueT    issue;
    exeResT   exeRes;
    regWriteT regWrite;                         // fed back to the register file

    decodeStage u_decodeStage (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .regWrite   (regWrite),
        .issue      (issue)
    );

    exeStage u_exeStage (
        .clk      (clk),
        .nrst     (nrst),
        .issue    (issue),
        .exeRes   (exeRes),
        .redirect (redirect)
    );

    writebackStage u_writebackStage (
        .clk      (clk),
        .nrst     (nrst),
        .exeRes   (exeRes),
        .regWrite (regWrite)
    );

    assign wb = regWrite;

endmodule

/* sim/exeTopTb.sv */
`timescale 1ns/1ps

module exeTopTb
    import rvPkg::*;
();

    localparam int waitLimit = 20;              // cycles before a wait gives up

    logic            clk;
    logic            nrst;
    logic            instrValid;
    logic [31:0]     instr;
    logic [xlen-1:0] pc;
    redirectT        redirect;
    regWriteT        wb;

    logic [xlen-1:0] model [regCount];          // reference register file
    regWriteT        wbQ [$];
    int              wbCycQ [$];
    redirectT        redirQ [$];
    int              cycle;
    int              checks;
    int              errors;
    int              timeouts;

    exeTop u_exeTop (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .redirect   (redirect),
        .wb         (wb)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // outputs are collected mid-cycle, away from the edge
    always @(negedge clk)
    begin
        if (nrst && wb.en)
        begin
            wbQ.push_back(wb);
            wbCycQ.push_back(cycle);
        end
        if (nrst && redirect.taken)
        begin
            redirQ.push_back(redirect);
        end
    end

    // instruction encoders, straight from the RV32I formats
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return sub ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b100: return a ^ b;
            3'b101: return a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkRegWrite(input string name, input regWriteT got, input regWriteT exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %0t %s: got en=%0b addr=%0d data=%h, exp en=%0b addr=%0d data=%h",
                     $time, name, got.en, got.addr, got.data, exp.en, exp.addr, exp.data);
        end
    endtask

    task automatic checkRedirect(input string name, input redirectT got, input redirectT exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %0t %s: got taken=%0b target=%h, exp taken=%0b target=%h",
                     $time, name, got.taken, got.target, exp.taken, exp.target);
        end
    endtask

    task automatic driveInstr(input logic [31:0] word, input logic [31:0] pcVal);
        @(posedge clk);
        #2;
        instrValid = 1'b1;
        instr      = word;
        pc         = pcVal;
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #2;
        instrValid = 1'b0;
        instr      = '0;
    endtask

    // wait until the monitor holds enough writes and redirects
    task automatic waitEvents(input int nWb, input int nRedir);
        int count;
        count = 0;
        while ((wbQ.size() < nWb || redirQ.size() < nRedir) && count < waitLimit)
        begin
            @(negedge clk);
            count++;
        end
        if (wbQ.size() < nWb || redirQ.size() < nRedir)
        begin
            timeouts++;
            $display("timeout at %0t waiting for %0d writes and %0d redirects",
                     $time, nWb, nRedir);
        end
    endtask

    task automatic expectQuiet(input int cycles);
        repeat (cycles) @(negedge clk);
        checks++;
        if (wbQ.size() != 0 || redirQ.size() != 0)
        begin
            errors++;
            $display("unexpected activity at %0t: %0d register writes, %0d redirects",
                     $time, wbQ.size(), redirQ.size());
            wbQ.delete();
            wbCycQ.delete();
            redirQ.delete();
        end
    endtask

    task automatic runWrite(input logic [31:0] word, input logic [4:0] rd,
                            input logic [31:0] expData);
        regWriteT exp;
        int       issueCyc;
        int       gotCyc;
        driveInstr(word, '0);
        issueCyc = cycle + 1;                   // captured at the next edge
        driveIdle();
        if (rd == 5'd0)
        begin
            expectQuiet(4);                     // x0 never writes back
        end
        else
        begin
            waitEvents(1, 0);
            if (wbQ.size() > 0)
            begin
                exp.en   = 1'b1;
                exp.addr = rd;
                exp.data = expData;
                checkRegWrite("wb", wbQ.pop_front(), exp);
                gotCyc = wbCycQ.pop_front();
                if (gotCyc != issueCyc + 2)
                begin
                    errors++;
                    $display("Fail %0t wb.en cycle: got %0d, exp %0d", $time, gotCyc,
                             issueCyc + 2);
                end
                model[rd] = expData;
            end
        end
    endtask

    task automatic loadReg(input logic [4:0] rd, input logic [31:0] val);
        logic [19:0] hi;
        logic [11:0] lo;
        lo = val[11:0];
        hi = val[31:12] + {19'b0, val[11]};     // addi sign extends the low part
        runWrite({hi, rd, opLui}, rd, {hi, 12'b0});
        runWrite(encI(lo, rd, 3'b000, rd, opOpImm), rd, model[rd] + {{20{lo[11]}}, lo});
    endtask

    task automatic aluOpCase(input logic [2:0] f3, input logic sub, input logic [4:0] rd);
        runWrite(encR(sub ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, rd), rd,
                 aluRef(f3, sub, model[1], model[2]));
    endtask

    task automatic testAlu();
        for (int n = 0; n < 2; n++)
        begin
            loadReg(5'd1, $urandom());
            loadReg(5'd2, $urandom());
            aluOpCase(3'b000, 1'b0, 5'd12);
            aluOpCase(3'b000, 1'b1, 5'd13);
            aluOpCase(3'b111, 1'b0, 5'd14);
            aluOpCase(3'b110, 1'b0, 5'd15);
            aluOpCase(3'b100, 1'b0, 5'd16);
            aluOpCase(3'b010, 1'b0, 5'd17);
            aluOpCase(3'b001, 1'b0, 5'd18);
            aluOpCase(3'b101, 1'b0, 5'd19);
        end
        runWrite(encI(12'h005, 5'd1, 3'b000, 5'd0, opOpImm), 5'd0, '0);
        runWrite({20'habcde, 5'd0, opLui}, 5'd0, '0);
        runWrite(encR(7'h00, 5'd1, 5'd0, 3'b000, 5'd4), 5'd4, model[1]);   // x0 reads zero
    endtask

    task automatic testBackToBack();
        regWriteT exp;
        int       firstCyc;
        int       gotCyc;
        driveInstr(encI(12'h011, 5'd1, 3'b000, 5'd5, opOpImm), '0);
        firstCyc = cycle + 1;
        driveInstr(encI(12'h022, 5'd1, 3'b000, 5'd6, opOpImm), '0);
        driveInstr(encI(12'h033, 5'd1, 3'b000, 5'd7, opOpImm), '0);
        driveIdle();
        waitEvents(3, 0);
        for (int n = 0; n < 3 && wbQ.size() > 0; n++)
        begin
            exp.en   = 1'b1;
            exp.addr = 5'd5 + 5'(n);
            exp.data = model[1] + 32'(17 * (n + 1));
            checkRegWrite("wb", wbQ.pop_front(), exp);
            gotCyc = wbCycQ.pop_front();
            if (gotCyc != firstCyc + 2 + n)
            begin
                errors++;
                $display("Fail %0t wb.en cycle: got %0d, exp %0d", $time, gotCyc,
                         firstCyc + 2 + n);
            end
            model[exp.addr] = exp.data;
        end
    endtask

    task automatic testBranch(input logic bne, input logic [31:0] a, input logic [31:0] b);
        redirectT    exp;
        logic [12:0] off;
        logic [31:0] pcVal;
        loadReg(5'd10, a);
        loadReg(5'd11, b);
        off    = 13'($urandom());
        off[0] = 1'b0;
        pcVal  = $urandom() & 32'hffff_fffc;
        driveInstr(encB(off, 5'd11, 5'd10, {2'b00, bne}), pcVal);
        driveIdle();
        if ((model[10] == model[11]) ^ bne)
        begin
            waitEvents(0, 1);
            exp.taken  = 1'b1;
            exp.target = pcVal + {{19{off[12]}}, off};
            if (redirQ.size() > 0)
            begin
                checkRedirect("redirect", redirQ.pop_front(), exp);
            end
        end
        expectQuiet(4);                         // no write, no further redirect
    endtask

    task automatic testJumps();
        redirectT    exp;
        logic [20:0] off;
        logic [11:0] imm;
        logic [31:0] pcVal;
        off    = 21'($urandom());
        off[0] = 1'b0;
        pcVal  = $urandom() & 32'hffff_fffc;
        driveInstr(encJ(off, 5'd9), pcVal);
        driveIdle();
        waitEvents(0, 1);
        exp.taken  = 1'b1;
        exp.target = pcVal + {{11{off[20]}}, off};
        if (redirQ.size() > 0)
        begin
            checkRedirect("redirect", redirQ.pop_front(), exp);
        end
        expectQuiet(4);
        loadReg(5'd10, $urandom());
        imm    = 12'($urandom());
        imm[0] = ~model[10][0];                 // odd sum, bit 0 must drop
        driveInstr(encI(imm, 5'd10, 3'b000, 5'd9, opJalr), pcVal);
        driveIdle();
        waitEvents(0, 1);
        exp.target = (model[10] + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
        if (redirQ.size() > 0)
        begin
            checkRedirect("redirect", redirQ.pop_front(), exp);
        end
        expectQuiet(4);
    endtask

    // consumer presented exactly three cycles after its producer
    task automatic testBypass();
        regWriteT exp;
        driveInstr(encI(12'h007, 5'd1, 3'b000, 5'd8, opOpImm), '0);
        driveIdle();
        driveIdle();
        driveInstr(encR(7'h00, 5'd2, 5'd8, 3'b000, 5'd20), '0);
        driveIdle();
        waitEvents(2, 0);
        if (wbQ.size() == 2)
        begin
            exp.en   = 1'b1;
            exp.addr = 5'd8;
            exp.data = model[1] + 32'd7;
            checkRegWrite("wb", wbQ.pop_front(), exp);
            model[8] = exp.data;
            exp.addr = 5'd20;
            exp.data = model[8] + model[2];
            checkRegWrite("wb", wbQ.pop_front(), exp);
            model[20] = exp.data;
        end
        wbCycQ.delete();
    endtask

    initial
    begin
        nrst       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        cycle      = 0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        void'($urandom(32'hc132));
        for (int i = 0; i < regCount; i++)
        begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        nrst = 1'b1;

        expectQuiet(6);                         // idle after reset
        testAlu();
        testBackToBack();
        testBranch(1'b0, 32'h1234_5678, 32'h1234_5678);
        testBranch(1'b0, 32'h1234_5678, 32'h8765_4321);
        testBranch(1'b1, 32'h0bad_f00d, 32'h0bad_f00d);
        testBranch(1'b1, 32'h0bad_f00d, 32'hf00d_0bad);
        testJumps();
        testBypass();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
hw/rvPkg.sv
hw/aluUnit.sv
hw/branchUnit.sv
hw/decodeStage.sv
hw/exeStage.sv
hw/writebackStage.sv
hw/exeTop.sv
sim/exeTopTb.sv

/* Bender.yml */
package:
  name: exeTop

sources:
  - hw/rvPkg.sv
  - hw/aluUnit.sv
  - hw/branchUnit.sv
  - hw/decodeStage.sv
  - hw/exeStage.sv
  - hw/writebackStage.sv
  - hw/exeTop.sv
  - target: simulation
    files:
      - sim/exeTopTb.sv
